// ==== verilog/buck_ctrl_consts.svh ====
// Phase count, register map, register values, supervisor limits and address macros
`ifndef BUCK_CTRL_CONSTS_SVH
`define BUCK_CTRL_CONSTS_SVH

// Converter size
`define N_PHASES 4

// PWM generator address map
`define PWM_BASE_ADDR 16'h4000
`define PHASE_STRIDE  16'h0100 // Phase p at base + stride * (p + 1)

// Register offsets within a block
`define REG_GLOBAL   8'h00
`define REG_COMPARE  8'h04
`define REG_DEADTIME 8'h08
`define REG_CNT_STOP 8'h10
`define REG_SHIFT    8'h14
`define REG_OUT_EN   8'h18
`define REG_DT_EN    8'h1C
`define REG_CHAIN    8'h20

// Register values
`define GLOBAL_OFF 32'h0000_1100
`define GLOBAL_ON  32'h0000_1128 // Counters running
`define DEADTIME   32'd5
`define OUT_EN_ON  32'd3 // High and low side
`define OUT_EN_OFF 32'd0
`define DT_EN_ON   32'd1
`define CHAIN_ON   32'd1

// Overcurrent supervisor
`define OC_LIMIT  12'd2400
`define OC_FILTER 3 // Consecutive over-limit samples to trip

// Address of the global control register
`define GLOBAL_ADDR (`PWM_BASE_ADDR + {8'h00, `REG_GLOBAL})

// Address of a register in the block of phase ph
`define PHASE_ADDR(ph, off) (`PWM_BASE_ADDR + `PHASE_STRIDE * (16'(ph) + 16'd1) + {8'h00, off})

`endif

// ==== verilog/buck_ctrl_pkg.sv ====
// Register write and request structs, processor state encoding
`default_nettype none

package buck_ctrl_pkg;

    // One write to the PWM generator register map
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } reg_write_t;

    // Write request as driven by a peer or by the arbiter, 49 bits
    typedef struct packed {
        logic       valid;
        reg_write_t write;
    } wr_req_t;

    // Pre-modulation processor sequencer
    typedef enum logic [2:0] {
        idle         = 3'd0, // Waiting for a command, single global writes go out from here
        chain_config = 3'd1, // Per-phase chain setup, five writes per phase
        shift_config = 3'd2, // One phase-shift write per phase
        duty_update  = 3'd3  // One compare write per phase
    } premod_state_t;

endpackage

`default_nettype wire

// ==== verilog/buck_premod_processor.sv ====
// Pre-modulation processor: configure, start, stop and duty-update write sequencer
`timescale 1ns/100ps
`default_nettype none
`include "buck_ctrl_consts.svh"

module buck_premod_processor import buck_ctrl_pkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire         configure,
    input  wire         start,
    input  wire         stop,
    input  wire         update,
    input  wire  [15:0] period,
    input  wire  [15:0] duty,
    input  wire  [15:0] phase_shift [`N_PHASES],
    input  wire         wr_accept,
    output wr_req_t     wr_req,
    output logic        wr_burst,
    output logic        done,
    output logic        modulator_on
);

    localparam int IDX_W = $clog2(`N_PHASES);
    localparam int CHAIN_STEPS = 5;
    localparam logic [IDX_W:0] PH_END = `N_PHASES; // One past the last phase

    premod_state_t state;
    premod_state_t state_n;
    logic [IDX_W:0] phase;
    logic [IDX_W:0] phase_n;
    logic [2:0] step; // Position in the chain setup of one phase
    logic [2:0] step_n;
    logic update_pending;
    logic take_update;
    logic free; // No write outstanding at the next edge
    logic issue;
    logic done_n;
    logic mod_on_n;
    logic req_valid;
    reg_write_t req_write;
    reg_write_t next_write;

    assign free = !req_valid || wr_accept;
    assign wr_req = '{valid: req_valid, write: req_write};
    assign wr_burst = (state != idle);

    always_comb begin
        state_n = state;
        phase_n = phase;
        step_n = step;
        issue = 1'b0;
        next_write = req_write;
        done_n = 1'b0;
        mod_on_n = modulator_on;
        take_update = 1'b0;

        if (free) begin
            case (state)
                idle: begin
                    // Configure, then stop, then start, then a pending update
                    if (configure) begin
                        issue = 1'b1;
                        next_write = '{addr: `GLOBAL_ADDR, data: `GLOBAL_OFF};
                        state_n = chain_config;
                        phase_n = '0;
                        step_n = '0;
                    end else if (stop) begin
                        issue = 1'b1;
                        next_write = '{addr: `GLOBAL_ADDR, data: `GLOBAL_OFF};
                        mod_on_n = 1'b0;
                    end else if (start) begin
                        issue = 1'b1;
                        next_write = '{addr: `GLOBAL_ADDR, data: `GLOBAL_ON};
                        mod_on_n = 1'b1;
                    end else if (update_pending && !modulator_on) begin
                        take_update = 1'b1;
                        state_n = duty_update;
                        phase_n = '0;
                    end
                end
                chain_config: begin
                    if (phase == PH_END) begin
                        state_n = shift_config;
                        phase_n = '0;
                    end else begin
                        issue = 1'b1;
                        case (step)
                            3'd0: next_write = '{addr: `PHASE_ADDR(phase, `REG_DEADTIME),
                                                 data: `DEADTIME};
                            3'd1: next_write = '{addr: `PHASE_ADDR(phase, `REG_CNT_STOP),
                                                 data: {16'h0000, period}};
                            3'd2: next_write = '{addr: `PHASE_ADDR(phase, `REG_OUT_EN),
                                                 data: `OUT_EN_ON};
                            3'd3: next_write = '{addr: `PHASE_ADDR(phase, `REG_DT_EN),
                                                 data: `DT_EN_ON};
                            default: next_write = '{addr: `PHASE_ADDR(phase, `REG_CHAIN),
                                                    data: `CHAIN_ON};
                        endcase
                        if (step == 3'(CHAIN_STEPS - 1)) begin // Phase finished
                            step_n = '0;
                            phase_n = phase + 1'b1;
                        end else begin
                            step_n = step + 3'd1;
                        end
                    end
                end
                shift_config: begin
                    if (phase == PH_END) begin // Last shift accepted
                        state_n = idle;
                        phase_n = '0;
                        done_n = 1'b1;
                    end else begin
                        issue = 1'b1;
                        next_write = '{addr: `PHASE_ADDR(phase, `REG_SHIFT),
                                       data: {16'h0000, phase_shift[phase[IDX_W-1:0]]}};
                        phase_n = phase + 1'b1;
                    end
                end
                duty_update: begin
                    if (phase == PH_END) begin
                        state_n = idle;
                        phase_n = '0;
                    end else begin
                        issue = 1'b1;
                        next_write = '{addr: `PHASE_ADDR(phase, `REG_COMPARE),
                                       data: {16'h0000, duty}};
                        phase_n = phase + 1'b1;
                    end
                end
                default: state_n = idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            phase <= '0;
            step <= '0;
            req_valid <= 1'b0;
            done <= 1'b0;
            modulator_on <= 1'b0;
            update_pending <= 1'b0;
        end else begin
            state <= state_n;
            phase <= phase_n;
            step <= step_n;
            req_valid <= issue || (req_valid && !wr_accept);
            done <= done_n;
            modulator_on <= mod_on_n;
            update_pending <= update || (update_pending && !take_update); // New pulse wins
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            req_write <= next_write;
        end
    end

    // Address and data held until the arbiter lets the write leave
    req_stable: assert property (@(posedge clock) disable iff (!reset)
        req_valid && !wr_accept |=> req_valid && $stable(req_write));

endmodule

`default_nettype wire

// ==== verilog/overcurrent_supervisor.sv ====
// Overcurrent supervisor: sample filter, trip latch and output-disable write burst
`timescale 1ns/100ps
`default_nettype none
`include "buck_ctrl_consts.svh"

module overcurrent_supervisor import buck_ctrl_pkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire  [11:0] current,
    input  wire         current_valid,
    input  wire         trip_clear,
    input  wire         wr_accept,
    output wr_req_t     wr_req,
    output logic        wr_burst,
    output logic        trip
);

    localparam int IDX_W = $clog2(`N_PHASES);
    localparam int CNT_W = $clog2(`OC_FILTER + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = `OC_FILTER - 1;

    logic [CNT_W-1:0] over_count; // Consecutive over-limit samples
    logic [IDX_W-1:0] phase; // Phase of the disable write on the bus
    logic req_valid;
    logic over_sample;
    logic fire;
    logic last_write;

    assign over_sample = current_valid && (current > `OC_LIMIT);
    // Samples are ignored while tripped or while a burst is still going out
    assign fire = over_sample && !trip && !wr_burst && (over_count == CNT_LAST);
    assign last_write = wr_accept && (phase == IDX_W'(`N_PHASES - 1));

    assign wr_req = '{valid: req_valid,
                      write: '{addr: `PHASE_ADDR(phase, `REG_OUT_EN), data: `OUT_EN_OFF}};

    always_ff @(posedge clock) begin
        if (!reset) begin
            over_count <= '0;
            trip <= 1'b0;
            wr_burst <= 1'b0;
            req_valid <= 1'b0;
            phase <= '0;
        end else begin
            if (fire) begin
                over_count <= '0;
            end else if (current_valid && !trip) begin
                if (!over_sample) begin
                    over_count <= '0; // Any low sample restarts the filter
                end else if (over_count != CNT_LAST) begin
                    over_count <= over_count + 1'b1;
                end
            end

            if (fire) begin
                trip <= 1'b1;
            end else if (trip_clear) begin
                trip <= 1'b0;
            end

            if (fire) begin // Disable burst from phase 0
                wr_burst <= 1'b1;
                req_valid <= 1'b1;
                phase <= '0;
            end else if (last_write) begin
                wr_burst <= 1'b0;
                req_valid <= 1'b0;
            end else if (wr_accept) begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Trip is a latch, only the host can release it
    trip_latched: assert property (@(posedge clock) disable iff (!reset)
        $fell(trip) |-> $past(trip_clear));

endmodule

`default_nettype wire

// ==== verilog/reg_write_arbiter.sv ====
// Fixed-priority arbiter for the shared register-write bus with burst lock
`timescale 1ns/100ps
`default_nettype none

module reg_write_arbiter import buck_ctrl_pkg::*; (
    input  wire     clock,
    input  wire     reset,
    input  wr_req_t sup_req,
    input  wr_req_t proc_req,
    input  wire     sup_burst,
    input  wire     proc_burst,
    input  wire     wr_ready,
    output wr_req_t wr_out,
    output logic    sup_accept,
    output logic    proc_accept
);

    logic sup_locked;
    logic proc_locked;
    logic sup_hold; // Lock still backed by a running burst
    logic proc_hold;
    logic grant_sup;

    assign sup_hold = sup_locked && sup_burst;
    assign proc_hold = proc_locked && proc_burst;

    // Supervisor first unless a processor burst owns the bus
    always_comb begin
        if (proc_hold) begin
            grant_sup = 1'b0;
        end else if (sup_hold) begin
            grant_sup = 1'b1;
        end else begin
            grant_sup = sup_req.valid;
        end
    end

    assign wr_out = grant_sup ? sup_req : proc_req; // Same-cycle path to the bus
    assign sup_accept = grant_sup && sup_req.valid && wr_ready;
    assign proc_accept = !grant_sup && proc_req.valid && wr_ready;

    // The first accepted write of a burst takes the lock
    always_ff @(posedge clock) begin
        if (!reset) begin
            sup_locked <= 1'b0;
            proc_locked <= 1'b0;
        end else begin
            sup_locked <= sup_burst && (sup_hold || sup_accept);
            proc_locked <= proc_burst && (proc_hold || proc_accept);
        end
    end

    one_accept: assert property (@(posedge clock) disable iff (!reset)
        !(sup_accept && proc_accept));

    // A locked grant keeps the same word on the bus while the outside stalls
    locked_stall_stable: assert property (@(posedge clock) disable iff (!reset)
        wr_out.valid && !wr_ready && (sup_hold || proc_hold) |=> $stable(wr_out));

endmodule

`default_nettype wire

// ==== verilog/buck_ctrl_top.sv ====
// Buck converter control top: processor, overcurrent supervisor and write arbiter
`timescale 1ns/100ps
`default_nettype none
`include "buck_ctrl_consts.svh"

module buck_ctrl_top import buck_ctrl_pkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire         configure,
    input  wire         start,
    input  wire         stop,
    input  wire         update,
    input  wire  [15:0] period,
    input  wire  [15:0] duty,
    input  wire  [15:0] phase_shift [`N_PHASES],
    input  wire  [11:0] current,
    input  wire         current_valid,
    input  wire         trip_clear,
    input  wire         wr_ready,
    output wr_req_t     wr_out,
    output logic        done,
    output logic        modulator_on,
    output logic        trip
);

    wr_req_t proc_req;
    wr_req_t sup_req;
    logic proc_burst;
    logic sup_burst;
    logic proc_accept;
    logic sup_accept;

    buck_premod_processor i_processor (
        .clock        (clock),
        .reset        (reset),
        .configure    (configure),
        .start        (start),
        .stop         (stop),
        .update       (update),
        .period       (period),
        .duty         (duty),
        .phase_shift  (phase_shift),
        .wr_accept    (proc_accept),
        .wr_req       (proc_req),
        .wr_burst     (proc_burst),
        .done         (done),
        .modulator_on (modulator_on)
    );

    overcurrent_supervisor i_supervisor (
        .clock         (clock),
        .reset         (reset),
        .current       (current),
        .current_valid (current_valid),
        .trip_clear    (trip_clear),
        .wr_accept     (sup_accept),
        .wr_req        (sup_req),
        .wr_burst      (sup_burst),
        .trip          (trip)
    );

    // Supervisor has priority on the shared bus
    reg_write_arbiter i_arbiter (
        .clock       (clock),
        .reset       (reset),
        .sup_req     (sup_req),
        .proc_req    (proc_req),
        .sup_burst   (sup_burst),
        .proc_burst  (proc_burst),
        .wr_ready    (wr_ready),
        .wr_out      (wr_out),
        .sup_accept  (sup_accept),
        .proc_accept (proc_accept)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_buck_ctrl.sv ====
// Testbench for buck_ctrl_top with stimulus reader, ready generator, write model and checks
`timescale 1ns/100ps
`default_nettype none
`include "buck_ctrl_consts.svh"

module tb_buck_ctrl import buck_ctrl_pkg::*; ();

    logic        clock;
    logic        reset;
    logic        configure;
    logic        start;
    logic        stop;
    logic        update;
    logic [15:0] period;
    logic [15:0] duty;
    logic [15:0] phase_shift [`N_PHASES];
    logic [11:0] current;
    logic        current_valid;
    logic        trip_clear;
    logic        wr_ready;
    wr_req_t     wr_out;
    logic        done;
    logic        modulator_on;
    logic        trip;

    logic [87:0] stim [64]; // Op code, then five 16-bit operands
    reg_write_t  proc_q [$];
    reg_write_t  sup_q [$];
    int          errors = 0;
    int          done_count = 0;
    int          done_taken = 0;
    logic        done_prev = 1'b0;
    logic        cfg_active = 1'b0; // Configure burst still expected on the bus
    int          cfg_sent = 0;
    logic        mod_model = 1'b0;
    logic        pending_model = 1'b0;
    logic        trip_model = 1'b0;
    int          over_model = 0;
    logic [31:0] rng = 32'h6f7b_3bf8;
    longint      watch_ns = 0;

    buck_ctrl_top i_buck_ctrl_top (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(negedge clock) begin
        rng = lcg_next(rng);
        wr_ready = (rng[31:30] != 2'b00); // High about 3 cycles of 4
    end

    // Phase -1 selects the global block
    function automatic logic [15:0] reg_addr(input int ph, input logic [7:0] off);
        return `PWM_BASE_ADDR + `PHASE_STRIDE * 16'(ph + 1) + {8'h00, off};
    endfunction

    task automatic expect_proc(input int ph, input logic [7:0] off, input logic [31:0] data);
        proc_q.push_back(reg_write_t'{addr: reg_addr(ph, off), data: data});
    endtask

    task automatic expect_duty_writes();
        for (int p = 0; p < `N_PHASES; p++) begin
            expect_proc(p, `REG_COMPARE, {16'h0000, duty});
        end
    endtask

    task automatic report_wrong(input string who, input reg_write_t got, input reg_write_t exp);
        errors++;
        $display("CHECK FAILED at %0t ns: %s wrote %h=%h, expected %h=%h",
                 $time, who, got.addr, got.data, exp.addr, exp.data);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0b, expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic take_proc(input reg_write_t got);
        reg_write_t exp;
        assert (proc_q.size() != 0) else report_problem("processor wrote with nothing expected");
        if (proc_q.size() != 0) begin
            exp = proc_q.pop_front();
            assert (got == exp) else report_wrong("processor", got, exp);
            // Supervisor writes only wait behind a configure burst that has begun
            assert (sup_q.size() == 0 || (cfg_active && cfg_sent > 0)) else
                report_problem("processor write went out ahead of supervisor writes");
            if (cfg_active) begin
                cfg_sent++;
                cfg_active = (cfg_sent < 25);
            end
        end
    endtask

    task automatic take_sup(input reg_write_t got);
        reg_write_t exp;
        assert (sup_q.size() != 0) else report_problem("supervisor wrote with nothing expected");
        if (sup_q.size() != 0) begin
            exp = sup_q.pop_front();
            assert (got == exp) else report_wrong("supervisor", got, exp);
            assert (!(cfg_active && cfg_sent > 0)) else
                report_problem("supervisor write broke into a configure burst");
        end
    endtask

    // Bus monitor, only the supervisor writes output enable off
    always @(posedge clock) begin
        if (reset && wr_out.valid && wr_ready) begin
            if (wr_out.write.addr[7:0] == `REG_OUT_EN && wr_out.write.data == 32'd0) begin
                take_sup(wr_out.write);
            end else begin
                take_proc(wr_out.write);
            end
        end
        if (reset && done) begin
            done_count++;
            assert (!done_prev) else report_problem("done stayed high for more than one cycle");
        end
        done_prev <= done;
    end

    task automatic drain_writes();
        while (proc_q.size() != 0 || sup_q.size() != 0) begin
            @(negedge clock);
        end
        @(negedge clock);
    endtask

    task automatic run_op(input logic [87:0] w);
        logic [7:0]  op;
        logic [15:0] a [5];
        op = w[87:80];
        for (int k = 0; k < 5; k++) begin
            a[k] = w[79 - 16 * k -: 16];
        end
        case (op)
            8'h01: begin
                period = a[0];
                for (int p = 0; p < `N_PHASES; p++) begin
                    phase_shift[p] = a[p + 1];
                end
                expect_proc(-1, `REG_GLOBAL, `GLOBAL_OFF);
                for (int p = 0; p < `N_PHASES; p++) begin
                    expect_proc(p, `REG_DEADTIME, `DEADTIME);
                    expect_proc(p, `REG_CNT_STOP, {16'h0000, a[0]});
                    expect_proc(p, `REG_OUT_EN, 32'd3);
                    expect_proc(p, `REG_DT_EN, 32'd1);
                    expect_proc(p, `REG_CHAIN, 32'd1);
                end
                for (int p = 0; p < `N_PHASES; p++) begin
                    expect_proc(p, `REG_SHIFT, {16'h0000, a[p + 1]});
                end
                cfg_active = 1'b1;
                cfg_sent = 0;
                configure = 1'b1;
                @(negedge clock);
                configure = 1'b0;
            end
            8'h02: begin
                expect_proc(-1, `REG_GLOBAL, `GLOBAL_ON);
                mod_model = 1'b1;
                start = 1'b1;
                @(negedge clock);
                start = 1'b0;
            end
            8'h03: begin
                expect_proc(-1, `REG_GLOBAL, `GLOBAL_OFF);
                if (pending_model) begin
                    expect_duty_writes(); // Held update goes out after the stop
                end
                pending_model = 1'b0;
                mod_model = 1'b0;
                stop = 1'b1;
                @(negedge clock);
                stop = 1'b0;
            end
            8'h04: begin
                duty = a[0];
                if (mod_model) begin
                    pending_model = 1'b1;
                end else begin
                    expect_duty_writes();
                end
                update = 1'b1;
                @(negedge clock);
                update = 1'b0;
            end
            8'h05: begin
                current = a[0][11:0];
                current_valid = 1'b1;
                @(negedge clock);
                current_valid = 1'b0;
                if (!trip_model) begin
                    if (a[0][11:0] > `OC_LIMIT) begin
                        over_model++;
                    end else begin
                        over_model = 0;
                    end
                    if (over_model == `OC_FILTER) begin
                        trip_model = 1'b1;
                        over_model = 0;
                        for (int p = 0; p < `N_PHASES; p++) begin
                            sup_q.push_back(reg_write_t'{addr: reg_addr(p, `REG_OUT_EN),
                                                         data: 32'd0});
                        end
                    end
                end
            end
            8'h06: begin
                trip_clear = 1'b1;
                @(negedge clock);
                trip_clear = 1'b0;
                trip_model = 1'b0;
            end
            8'h07: repeat (a[0]) @(negedge clock);
            8'h08: begin
                while (done_count == done_taken) begin
                    @(negedge clock);
                end
                done_taken++;
                assert (proc_q.size() == 0) else
                    report_problem("done came before all configure writes went out");
            end
            8'h09: drain_writes();
            8'h0a: check_flag("modulator_on", modulator_on, a[0][0]);
            8'h0b: check_flag("trip", trip, a[0][0]);
            default: report_problem("unknown operation in the stimulus file");
        endcase
    endtask

    initial begin
        int n;
        int stim_cycles;
        int writes;
        reset = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        period = '0;
        duty = '0;
        current = '0;
        current_valid = 1'b0;
        trip_clear = 1'b0;
        wr_ready = 1'b0;
        for (int p = 0; p < `N_PHASES; p++) begin
            phase_shift[p] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            stim[i] = '0;
        end
        $readmemh("testbench/buck_ctrl_stim.txt", stim);

        // Rough length of the run for the watchdog
        n = 0;
        stim_cycles = 5;
        writes = 0;
        while (n < 64 && stim[n][87:80] != 8'h00) begin
            stim_cycles += 2;
            case (stim[n][87:80])
                8'h01: writes += 25;
                8'h02, 8'h03: writes += 1;
                8'h04: writes += 4;
                8'h05: writes += 2;
                8'h07: stim_cycles += int'(stim[n][79:64]);
                default: ;
            endcase
            n++;
        end
        watch_ns = 40 * (stim_cycles + 64 * writes);

        repeat (5) @(posedge clock);
        @(negedge clock);
        assert (!wr_out.valid && !done && !modulator_on && !trip) else
            report_problem("outputs were not cleared by reset");
        reset = 1'b1;

        for (int i = 0; i < n; i++) begin
            run_op(stim[i]);
        end
        drain_writes();

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (watch_ns != 0);
        #(watch_ns);
        $display("ERROR: watchdog expired after %0d ns, expected writes never arrived", watch_ns);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/buck_ctrl_stim.txt ====
// Columns: op_a0_a1_a2_a3_a4, an 8-bit op then five 16-bit operands, all hex
// 01 configure(period, shift 0..3) 02 start 03 stop 04 update(duty) 05 sample(current)
// 06 clear trip 07 wait(a0 cycles) 08 wait for done 09 drain writes
// 0a expect modulator_on == a0 0b expect trip == a0 00 ends the list
01_0320_0000_00c8_0190_0258
08_0000_0000_0000_0000_0000
09_0000_0000_0000_0000_0000
0a_0000_0000_0000_0000_0000
02_0000_0000_0000_0000_0000
09_0000_0000_0000_0000_0000
0a_0001_0000_0000_0000_0000
04_0190_0000_0000_0000_0000
07_0008_0000_0000_0000_0000
0a_0001_0000_0000_0000_0000
03_0000_0000_0000_0000_0000
09_0000_0000_0000_0000_0000
0a_0000_0000_0000_0000_0000
04_0100_0000_0000_0000_0000
09_0000_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
05_0500_0000_0000_0000_0000
07_0004_0000_0000_0000_0000
0b_0000_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
09_0000_0000_0000_0000_0000
0b_0001_0000_0000_0000_0000
06_0000_0000_0000_0000_0000
0b_0000_0000_0000_0000_0000
01_03e8_0010_0020_0030_0040
07_000a_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
05_0a00_0000_0000_0000_0000
08_0000_0000_0000_0000_0000
02_0000_0000_0000_0000_0000
09_0000_0000_0000_0000_0000
0b_0001_0000_0000_0000_0000
0a_0001_0000_0000_0000_0000
06_0000_0000_0000_0000_0000
0b_0000_0000_0000_0000_0000

// ==== build.f ====
+incdir+verilog
verilog/buck_ctrl_pkg.sv
verilog/buck_premod_processor.sv
verilog/overcurrent_supervisor.sv
verilog/reg_write_arbiter.sv
verilog/buck_ctrl_top.sv
testbench/tb_buck_ctrl.sv

// ==== build.sh ====
#!/bin/sh
# Build the buck controller testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f build.f --top-module tb_buck_ctrl &&
{
    out=$(./obj_dir/Vtb_buck_ctrl)
    printf '%s\n' "$out"
    printf '%s\n' "$out" | grep -qx 'STATUS: PASS'
} || { echo "Simulation did not pass"; exit 1; }
